// ==== hw/exec_consts.svh ====
// ----------------------------------------------------------
// Execute stage constants
// Widths, functional-unit select bits and micro-op codes
// ----------------------------------------------------------
`ifndef EXEC_CONSTS_SVH
`define EXEC_CONSTS_SVH

`define EX_XLEN          32      // Data path width
`define EX_RD_W          5       // Register address width
`define EX_UOP_W         5       // Micro-op width
`define EX_FU_W          4       // One-hot unit select width
`define EX_TRAP_CAUSE_W  6       // Trap cause width

`define EX_FU_ALU        0       // Unit select bit positions
`define EX_FU_LSU        1
`define EX_FU_CFU        2
`define EX_FU_CSR        3

`define EX_ALU_ADD       5'b00001
`define EX_ALU_SUB       5'b00010
`define EX_ALU_XOR       5'b00011
`define EX_ALU_OR        5'b00100
`define EX_ALU_AND       5'b00101
`define EX_ALU_SLL       5'b00110
`define EX_ALU_SRL       5'b00111
`define EX_ALU_SRA       5'b01000
`define EX_ALU_SLT       5'b01001
`define EX_ALU_SLTU      5'b01010

// Conditional branches keep the top two bits clear
`define EX_CFU_BEQ       5'b00001
`define EX_CFU_BGE       5'b00010
`define EX_CFU_BGEU      5'b00011
`define EX_CFU_BLT       5'b00100
`define EX_CFU_BLTU      5'b00101
`define EX_CFU_BNE       5'b00110
`define EX_CFU_JALI      5'b10001  // Jumps carry 2 in the top bits
`define EX_CFU_JALR      5'b10010
`define EX_CFU_JMP       5'b10100
`define EX_CFU_TAKEN     5'b11001  // Resolved branch result codes
`define EX_CFU_NOT_TAKEN 5'b11010

`define EX_LSU_LOAD_BIT  3       // LSU micro-op flag bits
`define EX_LSU_STORE_BIT 4

`endif

// ==== hw/exec_pkg.sv ====
// ----------------------------------------------------------
// Execute stage types
// Operand B word, read as data or as a trap cause
// ----------------------------------------------------------
`default_nettype none

`include "exec_consts.svh"

package exec_pkg;

    // Trap view, cause sits in the low bits
    typedef struct packed {
        logic [`EX_XLEN-`EX_TRAP_CAUSE_W-1:0] pad;    // Always zero
        logic [`EX_TRAP_CAUSE_W-1:0]          cause;  // Trap cause code
    } exec_trap_view_t;

    // Stage 3 picks the view from its trap flag
    typedef union packed {
        logic [`EX_XLEN-1:0] data;   // Store data or CSR operand
        exec_trap_view_t     trap;   // Trap cause
    } exec_opr_b_t;

endpackage

`default_nettype wire

// ==== hw/exec_alu.sv ====
// ----------------------------------------------------------
// Integer ALU
// Add/sub, logic ops, shifts and set-less-than
// The sum and compare outputs also serve the LSU and branches
// ----------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

`include "exec_consts.svh"

module exec_alu (
    input  wire [`EX_UOP_W-1:0] i_uop,           // Micro-op
    input  wire                 i_is_alu,        // ALU selected
    input  wire                 i_cmp_unsigned,  // Unsigned compare for branches
    input  wire [`EX_XLEN-1:0]  i_lhs,           // Left operand
    input  wire [`EX_XLEN-1:0]  i_rhs,           // Right operand
    output logic [`EX_XLEN-1:0] o_result,        // ALU result
    output logic [`EX_XLEN-1:0] o_sum,           // lhs + rhs, address generation
    output logic                o_lt,            // lhs < rhs
    output logic                o_eq             // lhs == rhs
);

    localparam int MSB = `EX_XLEN - 1;
    localparam int SHW = $clog2(`EX_XLEN);

    logic [`EX_XLEN:0]  diff;       // Extra bit holds the borrow
    logic               lt_s;
    logic               lt_u;
    logic               op_sltu;
    logic [SHW-1:0]     shamt;

    // ------------------------------------------------------------
    // Shared adder and comparator
    // ------------------------------------------------------------
    assign o_sum   = i_lhs + i_rhs;                  // Add and address gen
    assign diff    = {1'b0, i_lhs} - {1'b0, i_rhs};  // Sub and compares
    assign o_eq    = (i_lhs == i_rhs);
    assign lt_u    = diff[`EX_XLEN];                 // Borrow out
    assign lt_s    = (i_lhs[MSB] != i_rhs[MSB]) ? i_lhs[MSB] : diff[MSB];
    assign op_sltu = i_is_alu && (i_uop == `EX_ALU_SLTU);
    assign o_lt    = (op_sltu || i_cmp_unsigned) ? lt_u : lt_s;
    assign shamt   = i_rhs[SHW-1:0];                 // Low 5 bits only

    // ------------------------------------------------------------
    // Result select
    // ------------------------------------------------------------
    always_comb begin
        o_result = '0;
        if (i_is_alu) begin
            case (i_uop)
                `EX_ALU_ADD:  o_result = o_sum;
                `EX_ALU_SUB:  o_result = diff[MSB:0];
                `EX_ALU_XOR:  o_result = i_lhs ^ i_rhs;
                `EX_ALU_OR:   o_result = i_lhs | i_rhs;
                `EX_ALU_AND:  o_result = i_lhs & i_rhs;
                `EX_ALU_SLL:  o_result = i_lhs << shamt;
                `EX_ALU_SRL:  o_result = i_lhs >> shamt;
                `EX_ALU_SRA:  o_result = $signed(i_lhs) >>> shamt;  // Sign fill
                `EX_ALU_SLT:  o_result = {{MSB{1'b0}}, o_lt};
                `EX_ALU_SLTU: o_result = {{MSB{1'b0}}, o_lt};
                default:      o_result = '0;                     // Unknown op
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hw/exec_branch_unit.sv ====
// ----------------------------------------------------------
// Branch unit
// Resolves conditional branches and forms jump targets
// ----------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

`include "exec_consts.svh"

module exec_branch_unit (
    input  wire                 i_is_cfu,        // CFU selected
    input  wire [`EX_UOP_W-1:0] i_uop,           // Micro-op
    input  wire [`EX_XLEN-1:0]  i_sum,           // opr_a + opr_b from ALU
    input  wire [`EX_XLEN-1:0]  i_opr_c,         // Precomputed target
    input  wire                 i_lt,            // ALU compare
    input  wire                 i_eq,
    output logic                o_cmp_unsigned,  // Ask ALU for unsigned lt
    output logic [`EX_UOP_W-1:0] o_uop,          // Micro-op to stage 3
    output logic [`EX_XLEN-1:0] o_opr_a          // Branch or jump target
);

    logic cond;
    logic jalr;
    logic taken;

    assign cond = i_is_cfu && (i_uop[`EX_UOP_W-1 -: 2] == 2'b00);  // Conditional
    assign jalr = i_is_cfu && (i_uop == `EX_CFU_JALR);

    assign o_cmp_unsigned = cond && ((i_uop == `EX_CFU_BLTU) ||
                                     (i_uop == `EX_CFU_BGEU));

    // Signedness of i_lt already set by o_cmp_unsigned
    always_comb begin
        case (i_uop)
            `EX_CFU_BEQ:  taken = i_eq;
            `EX_CFU_BNE:  taken = !i_eq;
            `EX_CFU_BLT:  taken = i_lt;
            `EX_CFU_BLTU: taken = i_lt;
            `EX_CFU_BGE:  taken = !i_lt;
            `EX_CFU_BGEU: taken = !i_lt;
            default:      taken = 1'b0;
        endcase
    end

    assign o_uop = !cond ? i_uop :                       // Jumps, other units
                   taken ? `EX_CFU_TAKEN : `EX_CFU_NOT_TAKEN;

    // Targets are halfword aligned
    assign o_opr_a = jalr ? {i_sum[`EX_XLEN-1:1], 1'b0} :
                            {i_opr_c[`EX_XLEN-1:1], 1'b0};

endmodule

`default_nettype wire

// ==== hw/exec_result_select.sv ====
// ----------------------------------------------------------
// Result select
// Picks operands A and B per unit, encodes trap causes
// and drives the forwarding flags
// ----------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

`include "exec_consts.svh"

module exec_result_select
    import exec_pkg::*;
(
    input  wire [`EX_FU_W-1:0]  i_fu,           // One-hot unit select
    input  wire [`EX_UOP_W-1:0] i_uop,          // Micro-op
    input  wire                 i_trap,         // Trap from decode
    input  wire [`EX_RD_W-1:0]  i_rd,           // Carries cause on trap
    input  wire [`EX_XLEN-1:0]  i_opr_a,
    input  wire [`EX_XLEN-1:0]  i_opr_c,
    input  wire [`EX_XLEN-1:0]  i_alu_result,
    input  wire [`EX_XLEN-1:0]  i_sum,          // Load/store address
    input  wire [`EX_XLEN-1:0]  i_cfu_opr_a,    // Branch target
    output logic [`EX_XLEN-1:0] o_opr_a,        // Next operand A
    output exec_opr_b_t         o_opr_b,        // Next operand B
    output logic                o_opr_b_load,   // Operand B load enable
    output logic                o_trap,
    output logic                o_fwd_load,     // Load in stage 2
    output logic                o_fwd_csr       // CSR op in stage 2
);

    logic fu_alu;
    logic fu_lsu;
    logic fu_cfu;
    logic fu_csr;

    assign fu_alu = i_fu[`EX_FU_ALU];
    assign fu_lsu = i_fu[`EX_FU_LSU];
    assign fu_cfu = i_fu[`EX_FU_CFU];
    assign fu_csr = i_fu[`EX_FU_CSR];

    // ------------------------------------------------------------
    // Operand A, AND-OR mux on the one-hot select
    // ------------------------------------------------------------
    assign o_opr_a = ({`EX_XLEN{fu_alu}} & i_alu_result) |
                     ({`EX_XLEN{fu_lsu}} & i_sum)        |
                     ({`EX_XLEN{fu_cfu}} & i_cfu_opr_a)  |
                     ({`EX_XLEN{fu_csr}} & i_opr_a);

    // ------------------------------------------------------------
    // Operand B, trap cause wins over data
    // ------------------------------------------------------------
    always_comb begin
        o_opr_b.data = '0;
        if (i_trap) begin
            o_opr_b.trap.cause = {{(`EX_TRAP_CAUSE_W-`EX_RD_W){1'b0}}, i_rd};
        end else if (fu_lsu || fu_csr) begin
            o_opr_b.data = i_opr_c;  // Store data or CSR operand
        end
    end

    assign o_opr_b_load = i_trap || fu_csr || (fu_lsu && i_uop[`EX_LSU_STORE_BIT]);
    assign o_trap       = i_trap;   // No traps raised in this stage
    assign o_fwd_load   = fu_lsu && i_uop[`EX_LSU_LOAD_BIT];
    assign o_fwd_csr    = fu_csr;

    // Decode never selects two units
    always_comb begin
        assert final ($onehot0(i_fu)) else $error("Unit select not one-hot");
    end

endmodule

`default_nettype wire

// ==== hw/exec_stage_reg.sv ====
// ----------------------------------------------------------
// Stage 3 pipeline register
// One-entry valid/busy register with flush
// Operand B loads only on its own enable
// ----------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

`include "exec_consts.svh"

module exec_stage_reg
    import exec_pkg::*;
(
    input  wire                  g_clk,
    input  wire                  g_resetn,
    input  wire                  i_valid,       // Item offered
    input  wire                  i_flush,       // Drop held item
    input  wire                  i_opr_b_load,  // Capture operand B
    input  wire [`EX_RD_W-1:0]   i_rd,
    input  wire [`EX_UOP_W-1:0]  i_uop,
    input  wire [`EX_FU_W-1:0]   i_fu,
    input  wire                  i_trap,
    input  wire [1:0]            i_size,
    input  wire [31:0]           i_instr,
    input  wire [`EX_XLEN-1:0]   i_opr_a,
    input  exec_opr_b_t          i_opr_b,
    input  wire                  i_s3_busy,     // Stage 3 stalled
    output logic                 o_busy,        // Back-pressure to stage 2
    output logic                 o_valid,
    output logic [`EX_RD_W-1:0]  o_rd,
    output logic [`EX_UOP_W-1:0] o_uop,
    output logic [`EX_FU_W-1:0]  o_fu,
    output logic                 o_trap,
    output logic [1:0]           o_size,
    output logic [31:0]          o_instr,
    output logic [`EX_XLEN-1:0]  o_opr_a,
    output exec_opr_b_t          o_opr_b
);

    logic accept;

    assign o_busy = o_valid && i_s3_busy;  // Held item not yet taken
    assign accept = i_valid && !o_busy;

    // ------------------------------------------------------------
    // Valid flag
    // ------------------------------------------------------------
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            o_valid <= 1'b0;
        end else if (i_flush) begin
            o_valid <= 1'b0;               // Flush beats a new item
        end else if (accept) begin
            o_valid <= 1'b1;
        end else if (!i_s3_busy) begin
            o_valid <= 1'b0;               // Item left, nothing new
        end
    end

    // ------------------------------------------------------------
    // Payload
    // ------------------------------------------------------------
    always_ff @(posedge g_clk) begin
        if (accept) begin
            o_rd    <= i_rd;
            o_uop   <= i_uop;
            o_fu    <= i_fu;
            o_trap  <= i_trap;
            o_size  <= i_size;
            o_instr <= i_instr;
            o_opr_a <= i_opr_a;
        end
    end

    // Operand B keeps its last value unless reloaded
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            o_opr_b <= '0;
        end else if (accept && i_opr_b_load) begin
            o_opr_b <= i_opr_b;
        end
    end

    // Stalled item holds until stage 3 takes it
    assert property (@(posedge g_clk) disable iff (!g_resetn)
        o_valid && i_s3_busy && !i_flush |=>
            $stable({o_valid, o_rd, o_uop, o_fu, o_trap, o_size, o_instr,
                     o_opr_a, o_opr_b}))
        else $error("Stage 3 outputs changed under busy");

endmodule

`default_nettype wire

// ==== hw/exec_stage.sv ====
// ----------------------------------------------------------
// Execute stage top level
// ALU, branch unit and result select into the stage 3 register
// ----------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

`include "exec_consts.svh"

module exec_stage
    import exec_pkg::*;
(
    input  wire                  g_clk,
    input  wire                  g_resetn,
    input  wire                  i_s2_valid,   // Stage 2 item
    input  wire [`EX_RD_W-1:0]   i_s2_rd,
    input  wire [`EX_XLEN-1:0]   i_s2_opr_a,
    input  wire [`EX_XLEN-1:0]   i_s2_opr_b,
    input  wire [`EX_XLEN-1:0]   i_s2_opr_c,
    input  wire [`EX_UOP_W-1:0]  i_s2_uop,
    input  wire [`EX_FU_W-1:0]   i_s2_fu,
    input  wire                  i_s2_trap,
    input  wire [1:0]            i_s2_size,
    input  wire [31:0]           i_s2_instr,
    output logic                 o_s2_busy,
    input  wire                  i_flush,
    output logic [`EX_RD_W-1:0]  o_fwd_rd,     // To hazard logic
    output logic [`EX_XLEN-1:0]  o_fwd_wdata,
    output logic                 o_fwd_load,
    output logic                 o_fwd_csr,
    output logic                 o_s3_valid,   // Stage 3 item
    output logic [`EX_RD_W-1:0]  o_s3_rd,
    output logic [`EX_XLEN-1:0]  o_s3_opr_a,
    output exec_opr_b_t          o_s3_opr_b,
    output logic [`EX_UOP_W-1:0] o_s3_uop,
    output logic [`EX_FU_W-1:0]  o_s3_fu,
    output logic                 o_s3_trap,
    output logic [1:0]           o_s3_size,
    output logic [31:0]          o_s3_instr,
    input  wire                  i_s3_busy
);

    logic [`EX_XLEN-1:0]  alu_result;
    logic [`EX_XLEN-1:0]  alu_sum;
    logic                 alu_lt;
    logic                 alu_eq;
    logic                 cmp_unsigned;   // From branch unit
    logic [`EX_UOP_W-1:0] n_uop;          // Branch result code or passthrough
    logic [`EX_XLEN-1:0]  cfu_opr_a;
    exec_opr_b_t          n_opr_b;
    logic                 n_opr_b_load;
    logic                 n_trap;

    assign o_fwd_rd = i_s2_rd;

    exec_alu u_alu (
        .i_uop          (i_s2_uop),
        .i_is_alu       (i_s2_fu[`EX_FU_ALU]),
        .i_cmp_unsigned (cmp_unsigned),
        .i_lhs          (i_s2_opr_a),
        .i_rhs          (i_s2_opr_b),
        .o_result       (alu_result),
        .o_sum          (alu_sum),
        .o_lt           (alu_lt),
        .o_eq           (alu_eq)
    );

    exec_branch_unit u_branch (
        .i_is_cfu       (i_s2_fu[`EX_FU_CFU]),
        .i_uop          (i_s2_uop),
        .i_sum          (alu_sum),
        .i_opr_c        (i_s2_opr_c),
        .i_lt           (alu_lt),
        .i_eq           (alu_eq),
        .o_cmp_unsigned (cmp_unsigned),
        .o_uop          (n_uop),
        .o_opr_a        (cfu_opr_a)
    );

    exec_result_select u_select (
        .i_fu           (i_s2_fu),
        .i_uop          (i_s2_uop),
        .i_trap         (i_s2_trap),
        .i_rd           (i_s2_rd),
        .i_opr_a        (i_s2_opr_a),
        .i_opr_c        (i_s2_opr_c),
        .i_alu_result   (alu_result),
        .i_sum          (alu_sum),
        .i_cfu_opr_a    (cfu_opr_a),
        .o_opr_a        (o_fwd_wdata),    // Next operand A doubles as fwd data
        .o_opr_b        (n_opr_b),
        .o_opr_b_load   (n_opr_b_load),
        .o_trap         (n_trap),
        .o_fwd_load     (o_fwd_load),
        .o_fwd_csr      (o_fwd_csr)
    );

    exec_stage_reg u_stage_reg (
        .g_clk          (g_clk),
        .g_resetn       (g_resetn),
        .i_valid        (i_s2_valid),
        .i_flush        (i_flush),
        .i_opr_b_load   (n_opr_b_load),
        .i_rd           (i_s2_rd),
        .i_uop          (n_uop),
        .i_fu           (i_s2_fu),
        .i_trap         (n_trap),
        .i_size         (i_s2_size),
        .i_instr        (i_s2_instr),
        .i_opr_a        (o_fwd_wdata),
        .i_opr_b        (n_opr_b),
        .i_s3_busy      (i_s3_busy),
        .o_busy         (o_s2_busy),
        .o_valid        (o_s3_valid),
        .o_rd           (o_s3_rd),
        .o_uop          (o_s3_uop),
        .o_fu           (o_s3_fu),
        .o_trap         (o_s3_trap),
        .o_size         (o_s3_size),
        .o_instr        (o_s3_instr),
        .o_opr_a        (o_s3_opr_a),
        .o_opr_b        (o_s3_opr_b)
    );

endmodule

`default_nettype wire

// ==== verification/tb_exec_stage.sv ====
// ----------------------------------------------------------
// Execute stage testbench
// Random stage 2 items under random stage 3 back-pressure,
// checked against a reference model of the stage 3 register
// ----------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

`include "exec_consts.svh"

module tb_exec_stage
    import exec_pkg::*;
();

    localparam int NUM_CYCLES  = 3000;
    localparam int DRAIN_LIMIT = 40;    // Cycles allowed to empty stage 3

    logic                 g_clk;
    logic                 g_resetn;
    logic                 i_s2_valid;
    logic [`EX_RD_W-1:0]  i_s2_rd;
    logic [`EX_XLEN-1:0]  i_s2_opr_a;
    logic [`EX_XLEN-1:0]  i_s2_opr_b;
    logic [`EX_XLEN-1:0]  i_s2_opr_c;
    logic [`EX_UOP_W-1:0] i_s2_uop;
    logic [`EX_FU_W-1:0]  i_s2_fu;
    logic                 i_s2_trap;
    logic [1:0]           i_s2_size;
    logic [31:0]          i_s2_instr;
    logic                 o_s2_busy;
    logic                 i_flush;
    logic [`EX_RD_W-1:0]  o_fwd_rd;
    logic [`EX_XLEN-1:0]  o_fwd_wdata;
    logic                 o_fwd_load;
    logic                 o_fwd_csr;
    logic                 o_s3_valid;
    logic [`EX_RD_W-1:0]  o_s3_rd;
    logic [`EX_XLEN-1:0]  o_s3_opr_a;
    exec_opr_b_t          o_s3_opr_b;
    logic [`EX_UOP_W-1:0] o_s3_uop;
    logic [`EX_FU_W-1:0]  o_s3_fu;
    logic                 o_s3_trap;
    logic [1:0]           o_s3_size;
    logic [31:0]          o_s3_instr;
    logic                 i_s3_busy;

    // One expected stage 3 item
    typedef struct packed {
        logic [`EX_RD_W-1:0]  rd;
        logic [`EX_UOP_W-1:0] uop;
        logic [`EX_FU_W-1:0]  fu;
        logic                 trap;
        logic [1:0]           size;
        logic [31:0]          instr;
        logic [`EX_XLEN-1:0]  opr_a;
        logic [`EX_XLEN-1:0]  opr_b;
    } expected_item_t;

    expected_item_t      expected_q [$];    // Items held in stage 3
    logic [`EX_XLEN-1:0] model_opr_b;       // Model of the operand B register
    logic                hold_s2;           // Stage 2 item stalled, keep it
    integer              seed;
    int                  error_count;
    int                  n_done;            // Items seen leaving stage 3
    int                  n_flushed;
    string               test_name;

    exec_stage dut (.*);

    initial g_clk = 1'b0;
    always #2 g_clk = ~g_clk;               // 4 ns period

    // ------------------------------------------------------------
    // Random helpers and reference model
    // ------------------------------------------------------------
    function automatic int unsigned rand_below(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic logic [`EX_UOP_W-1:0] pick_uop(input logic [`EX_FU_W-1:0] fu);
        logic [31:0]          r;
        logic [`EX_UOP_W-1:0] uop;
        r   = $random(seed);
        uop = r[`EX_UOP_W-1:0];              // CSR ops take any code
        if (fu[`EX_FU_ALU]) begin
            case (rand_below(10))
                0: uop = `EX_ALU_ADD;
                1: uop = `EX_ALU_SUB;
                2: uop = `EX_ALU_XOR;
                3: uop = `EX_ALU_OR;
                4: uop = `EX_ALU_AND;
                5: uop = `EX_ALU_SLL;
                6: uop = `EX_ALU_SRL;
                7: uop = `EX_ALU_SRA;
                8: uop = `EX_ALU_SLT;
                default: uop = `EX_ALU_SLTU;
            endcase
        end else if (fu[`EX_FU_CFU]) begin
            case (rand_below(9))
                0: uop = `EX_CFU_BEQ;
                1: uop = `EX_CFU_BNE;
                2: uop = `EX_CFU_BLT;
                3: uop = `EX_CFU_BGE;
                4: uop = `EX_CFU_BLTU;
                5: uop = `EX_CFU_BGEU;
                6: uop = `EX_CFU_JALI;
                7: uop = `EX_CFU_JALR;
                default: uop = `EX_CFU_JMP;
            endcase
        end else if (fu[`EX_FU_LSU]) begin
            uop[`EX_LSU_STORE_BIT] = (rand_below(2) == 0);
            uop[`EX_LSU_LOAD_BIT]  = !uop[`EX_LSU_STORE_BIT];  // Load or store, never both
        end
        return uop;
    endfunction

    function automatic logic [`EX_XLEN-1:0] alu_model(input logic [`EX_UOP_W-1:0] op,
                                                     input logic [`EX_XLEN-1:0] a,
                                                     input logic [`EX_XLEN-1:0] b);
        case (op)
            `EX_ALU_ADD:  return a + b;
            `EX_ALU_SUB:  return a - b;
            `EX_ALU_XOR:  return a ^ b;
            `EX_ALU_OR:   return a | b;
            `EX_ALU_AND:  return a & b;
            `EX_ALU_SLL:  return a << b[4:0];
            `EX_ALU_SRL:  return a >> b[4:0];
            `EX_ALU_SRA:  return $signed(a) >>> b[4:0];   // Sign fill
            `EX_ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            `EX_ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
            default:      return '0;
        endcase
    endfunction

    // Expected stage 3 fields for the item now on stage 2
    task automatic model_next(output logic [`EX_XLEN-1:0] opr_a,
                              output logic [`EX_XLEN-1:0] opr_b,
                              output logic load_b, output logic [`EX_UOP_W-1:0] uop);
        logic [`EX_XLEN-1:0] a;
        logic [`EX_XLEN-1:0] b;
        logic                taken;
        a      = i_s2_opr_a;
        b      = i_s2_opr_b;
        uop    = i_s2_uop;
        opr_a  = '0;
        if (i_s2_fu[`EX_FU_ALU]) opr_a = alu_model(i_s2_uop, a, b);
        if (i_s2_fu[`EX_FU_LSU]) opr_a = a + b;            // Address
        if (i_s2_fu[`EX_FU_CSR]) opr_a = a;
        if (i_s2_fu[`EX_FU_CFU]) begin
            opr_a = (i_s2_uop == `EX_CFU_JALR) ? ((a + b) & ~32'd1) : (i_s2_opr_c & ~32'd1);
            case (i_s2_uop)
                `EX_CFU_BEQ:  taken = (a == b);
                `EX_CFU_BNE:  taken = (a != b);
                `EX_CFU_BLT:  taken = ($signed(a) < $signed(b));
                `EX_CFU_BGE:  taken = ($signed(a) >= $signed(b));
                `EX_CFU_BLTU: taken = (a < b);
                default:      taken = (a >= b);             // BGEU
            endcase
            if (i_s2_uop[`EX_UOP_W-1 -: 2] == 2'b00) uop = taken ? `EX_CFU_TAKEN : `EX_CFU_NOT_TAKEN;
        end
        load_b = i_s2_trap || i_s2_fu[`EX_FU_CSR] ||
                 (i_s2_fu[`EX_FU_LSU] && i_s2_uop[`EX_LSU_STORE_BIT]);
        opr_b  = i_s2_trap ? {{(`EX_XLEN-`EX_RD_W){1'b0}}, i_s2_rd} : i_s2_opr_c;
    endtask

    // ------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------
    task automatic check_value(input string field, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            error_count++;
            $display("Mismatch %s %s item %0d: expected 0x%08h, actual 0x%08h",
                     test_name, field, n_done, expected, actual);
            $display("Simulation failed");
            $fatal(1, "Stopped at first mismatch");
        end
    endtask

    task automatic compare_head();
        expected_item_t item;
        item = expected_q[0];
        check_value("s3_rd", item.rd, o_s3_rd);
        check_value("s3_uop", item.uop, o_s3_uop);
        check_value("s3_fu", item.fu, o_s3_fu);
        check_value("s3_trap", item.trap, o_s3_trap);
        check_value("s3_size", item.size, o_s3_size);
        check_value("s3_instr", item.instr, o_s3_instr);
        check_value("s3_opr_a", item.opr_a, o_s3_opr_a);
        check_value("s3_opr_b", item.opr_b, o_s3_opr_b.data);
        if (item.trap) check_value("s3_trap_cause", item.rd, o_s3_opr_b.trap.cause);
    endtask

    // Check the settled outputs, then step the model over the next edge
    task automatic check_cycle();
        expected_item_t       item;
        logic [`EX_XLEN-1:0]  e_opr_a;
        logic [`EX_XLEN-1:0]  e_opr_b;
        logic                 e_load;
        logic [`EX_UOP_W-1:0] e_uop;
        logic                 e_valid;
        logic                 e_busy;
        model_next(e_opr_a, e_opr_b, e_load, e_uop);
        e_valid = (expected_q.size() != 0);
        e_busy  = e_valid && i_s3_busy;
        check_value("fwd_rd", i_s2_rd, o_fwd_rd);
        check_value("fwd_wdata", e_opr_a, o_fwd_wdata);
        check_value("fwd_load", i_s2_fu[`EX_FU_LSU] && i_s2_uop[`EX_LSU_LOAD_BIT], o_fwd_load);
        check_value("fwd_csr", i_s2_fu[`EX_FU_CSR], o_fwd_csr);
        check_value("s3_valid", e_valid, o_s3_valid);
        check_value("s2_busy", e_busy, o_s2_busy);
        if (e_valid) compare_head();                 // Also covers hold under busy
        if (e_valid && !i_s3_busy) begin             // Handshake at next edge
            expected_q.delete(0);
            n_done++;
        end
        if (i_s2_valid && !e_busy) begin             // Accepted at next edge
            if (e_load) model_opr_b = e_opr_b;
            item = '{i_s2_rd, e_uop, i_s2_fu, i_s2_trap, i_s2_size, i_s2_instr,
                     e_opr_a, model_opr_b};
            expected_q.push_back(item);
        end
        if (i_flush) begin                           // Pending item dropped
            n_flushed += expected_q.size();
            expected_q.delete();
        end
        hold_s2 = i_s2_valid && e_busy;
    endtask

    // ------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------
    task automatic drive_inputs();
        logic [31:0] r;
        r         = $random(seed);
        i_s3_busy = r[0];                            // Stall about half the cycles
        i_flush   = (r[8:4] == 5'd0);
        if (i_flush) i_s3_busy = 1'b1;               // Flush a held item
        if (!hold_s2) begin
            i_s2_valid = (r[3:2] != 2'd0);
            i_s2_fu    = 4'b0001 << r[11:10];
            i_s2_uop   = pick_uop(i_s2_fu);
            i_s2_rd    = r[16:12];
            i_s2_trap  = (r[19:17] == 3'd0);
            i_s2_size  = r[21:20];
            i_s2_instr = $random(seed);
            i_s2_opr_a = $random(seed);
            i_s2_opr_b = (r[23:22] == 2'd0) ? i_s2_opr_a : $random(seed);  // Equal operands
            i_s2_opr_c = $random(seed);
        end
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while (expected_q.size() != 0 || o_s3_valid) begin
            if (cycles == DRAIN_LIMIT) begin
                $display("Timeout waiting for stage 3 to drain");
                $display("Simulation failed");
                $fatal(1, "Drain timeout");
            end
            @(negedge g_clk);
            i_s2_valid = 1'b0;
            i_s3_busy  = 1'b0;
            i_flush    = 1'b0;
            #1;
            check_cycle();
            cycles++;
        end
    endtask

    initial begin
        seed        = 79614;
        error_count = 0;
        n_done      = 0;
        n_flushed   = 0;
        hold_s2     = 1'b0;
        model_opr_b = '0;
        g_resetn    = 1'b0;
        i_s2_valid  = 1'b0;
        i_s2_rd     = '0;
        i_s2_opr_a  = '0;
        i_s2_opr_b  = '0;
        i_s2_opr_c  = '0;
        i_s2_uop    = '0;
        i_s2_fu     = '0;
        i_s2_trap   = 1'b0;
        i_s2_size   = '0;
        i_s2_instr  = '0;
        i_flush     = 1'b0;
        i_s3_busy   = 1'b0;
        test_name   = "reset";
        repeat (16) @(posedge g_clk);
        @(negedge g_clk);
        check_value("s3_valid", 1'b0, o_s3_valid);
        check_value("s2_busy", 1'b0, o_s2_busy);
        check_value("s3_opr_b", '0, o_s3_opr_b.data);
        g_resetn  = 1'b1;
        test_name = "random";
        repeat (NUM_CYCLES) begin
            @(negedge g_clk);
            drive_inputs();
            #1;                                      // Outputs settled before the edge
            check_cycle();
        end
        test_name = "drain";
        wait_drain();
        $display("Items checked %0d, items flushed %0d", n_done, n_flushed);
        if (error_count == 0 && n_done > 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Run ended with %0d errors and %0d items checked", error_count, n_done);
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+hw
hw/exec_pkg.sv
hw/exec_alu.sv
hw/exec_branch_unit.sv
hw/exec_result_select.sv
hw/exec_stage_reg.sv
hw/exec_stage.sv
verification/tb_exec_stage.sv
